// ==== src/spi_tx_defs.svh ====
/*
  SPI transmitter build constants: divider exponent, FIFO depth, counter width
*/
`ifndef SPI_TX_DEFS_SVH
`define SPI_TX_DEFS_SVH

// log2 of system clocks per SPI bit
`define SPI_CLK_DIVIDE 3

// Byte FIFO entries between host and sequencer
`define SPI_FIFO_DEPTH 8

// Width of the finished-byte counter
`define SPI_COUNT_W 16

`endif

// ==== src/spi_tx_pkg.sv ====
/*
  SPI transmitter types: data byte, master state, pin group and byte counter
*/
`include "spi_tx_defs.svh"

package spi_tx_pkg;

  typedef logic [7:0] spi_byte_t;

  // Master controller states, encoding order matters to the checker
  typedef enum logic [1:0] {
    IDLE,
    SEND,
    HOLD,
    DONE
  } spi_state_e;

  // The three SPI lines driven by the master
  typedef struct packed {
    logic csn;
    logic sclk;
    logic sdo;
  } spi_pins_t;

  typedef logic [`SPI_COUNT_W-1:0] spi_count_t;

endpackage

// ==== src/spi_tx_fifo.sv ====
/*
  Show-ahead byte FIFO, push and pop strobes with empty and full levels
*/
`timescale 1ns/1ps
`include "spi_tx_defs.svh"

module spi_tx_fifo #(
  parameter int DEPTH = `SPI_FIFO_DEPTH
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push,
  input  spi_tx_pkg::spi_byte_t wr_data,
  input  logic                  pop,
  output spi_tx_pkg::spi_byte_t rd_data,
  output logic                  empty,
  output logic                  full
);
  import spi_tx_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  spi_byte_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Push into a full FIFO and pop from an empty one are ignored
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));

  // Head entry is visible without a pop
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== src/spi_master.sv ====
/*
  SPI byte shift engine, MSB first on sdo with csn and sclk
  Start is a level held through DONE, fin reports the end of the byte
*/
`timescale 1ns/1ps
`include "spi_tx_defs.svh"

module spi_master #(
  parameter int CLK_DIVIDE = `SPI_CLK_DIVIDE
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  spi_tx_pkg::spi_byte_t data,
  output logic                  fin,
  output spi_tx_pkg::spi_pins_t pins
);
  import spi_tx_pkg::*;

  spi_state_e            state;
  logic [CLK_DIVIDE-1:0] clk_divider;
  spi_byte_t             data_shift;
  logic [2:0]            shift_counter;
  logic                  div_wrap;

  // Last system clock of an SPI bit period
  assign div_wrap = &clk_divider;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= IDLE;
      clk_divider   <= '0;
      shift_counter <= '0;
      data_shift    <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state         <= SEND;
            clk_divider   <= '0;
            shift_counter <= '0;
            data_shift    <= data;
          end
        end

        SEND: begin
          clk_divider <= clk_divider + 1'b1;
          // Next bit goes out at the divider wrap, after the rising sclk
          if (div_wrap) begin
            data_shift    <= {data_shift[6:0], 1'b0};
            shift_counter <= shift_counter + 3'd1;
            if (shift_counter == 3'd7) begin
              state <= HOLD;
            end
          end
        end

        HOLD: begin
          // One quiet bit period with csn still low
          clk_divider <= clk_divider + 1'b1;
          if (div_wrap) begin
            state <= DONE;
          end
        end

        DONE: begin
          if (!start) begin
            state <= IDLE;
          end
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  assign fin = (state == DONE);

  // csn falls in the same cycle start is seen in IDLE
  // sclk is high for the second half of each bit
  assign pins = '{
    csn:  (state == IDLE) && !start,
    sclk: (state == SEND) && clk_divider[CLK_DIVIDE-1],
    sdo:  data_shift[7]
  };

endmodule

// ==== src/spi_tx_sequencer.sv ====
/*
  Transfer sequencer: pops one byte, holds start until fin, counts bytes
*/
`timescale 1ns/1ps

module spi_tx_sequencer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   empty,
  output logic                   pop,
  input  spi_tx_pkg::spi_byte_t  rd_data,
  output logic                   start,
  output spi_tx_pkg::spi_byte_t  data,
  input  logic                   fin,
  output logic                   byte_done,
  output spi_tx_pkg::spi_count_t bytes_sent
);
  import spi_tx_pkg::*;

  logic busy;

  // Busy covers the whole byte, including the cycle after start drops
  assign pop = !busy && !empty;

  always_ff @(posedge clk) begin
    if (pop) begin
      data <= rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      start      <= 1'b0;
      byte_done  <= 1'b0;
      bytes_sent <= '0;
    end else begin
      byte_done <= 1'b0;

      if (pop) begin
        busy  <= 1'b1;
        start <= 1'b1;
      end else if (start && fin) begin
        // Master finished, release it and count the byte
        start      <= 1'b0;
        byte_done  <= 1'b1;
        bytes_sent <= bytes_sent + 1'b1;
      end else if (busy && !start) begin
        // Master leaves DONE on this edge
        busy <= 1'b0;
      end
    end
  end

endmodule

// ==== src/spi_tx_top.sv ====
/*
  Write-only SPI transmitter: host FIFO, transfer sequencer and SPI master
*/
`timescale 1ns/1ps

module spi_tx_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push,
  input  spi_tx_pkg::spi_byte_t  push_data,
  output logic                   full,
  output logic                   empty,
  output spi_tx_pkg::spi_pins_t  pins,
  output logic                   byte_done,
  output spi_tx_pkg::spi_count_t bytes_sent
);
  import spi_tx_pkg::*;

  spi_byte_t fifo_rd_data;
  logic      fifo_pop;
  logic      seq_start;
  spi_byte_t seq_data;
  logic      master_fin;

  spi_tx_fifo fifo0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .push    (push),
    .wr_data (push_data),
    .pop     (fifo_pop),
    .rd_data (fifo_rd_data),
    .empty   (empty),
    .full    (full)
  );

  spi_tx_sequencer seq0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .empty      (empty),
    .pop        (fifo_pop),
    .rd_data    (fifo_rd_data),
    .start      (seq_start),
    .data       (seq_data),
    .fin        (master_fin),
    .byte_done  (byte_done),
    .bytes_sent (bytes_sent)
  );

  spi_master master0 (
    .clk   (clk),
    .rst_n (rst_n),
    .start (seq_start),
    .data  (seq_data),
    .fin   (master_fin),
    .pins  (pins)
  );

endmodule

// ==== tests/spi_master_props.sv ====
/*
  SPI master checker: state machine, divider, shifting and start-to-fin latency
*/
`timescale 1ns/1ps
`include "spi_tx_defs.svh"

module spi_master_props #(
  parameter int CLK_DIVIDE = `SPI_CLK_DIVIDE
) (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   start,
  input spi_tx_pkg::spi_byte_t  data,
  input logic                   fin,
  input spi_tx_pkg::spi_pins_t  pins,
  input spi_tx_pkg::spi_state_e state,
  input logic [CLK_DIVIDE-1:0]  clk_divider,
  input spi_tx_pkg::spi_byte_t  data_shift,
  input logic [2:0]             shift_counter
);
  import spi_tx_pkg::*;

  localparam int P           = 1 << CLK_DIVIDE;
  localparam int FIN_LATENCY = 9 * P;

  logic      div_wrap;
  logic      last_bit;
  spi_byte_t sent_byte;

  assign div_wrap = &clk_divider;
  assign last_bit = div_wrap && (shift_counter == 3'd7);

  // Byte taken by the master when it leaves IDLE
  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      sent_byte <= data;
    end
  end

  // State transitions
  a_idle_start: assert property (@(posedge clk) disable iff (!rst_n)
    state == IDLE && start |=> state == SEND)
    else $error("IDLE with start did not move to SEND");

  a_idle_stay: assert property (@(posedge clk) disable iff (!rst_n)
    state == IDLE && !start |=> state == IDLE)
    else $error("IDLE left without start");

  a_send_end: assert property (@(posedge clk) disable iff (!rst_n)
    state == SEND && last_bit |=> state == HOLD)
    else $error("SEND did not move to HOLD after the eighth bit");

  a_send_stay: assert property (@(posedge clk) disable iff (!rst_n)
    state == SEND && !last_bit |=> state == SEND)
    else $error("SEND left before the eighth bit");

  a_hold_end: assert property (@(posedge clk) disable iff (!rst_n)
    state == HOLD |=> state == ($past(div_wrap) ? DONE : HOLD))
    else $error("HOLD did not last one bit period");

  a_done_wait: assert property (@(posedge clk) disable iff (!rst_n)
    state == DONE |=> state == ($past(start) ? DONE : IDLE))
    else $error("DONE did not wait for start to drop");

  // Divider runs freely in SEND and HOLD
  a_div_step: assert property (@(posedge clk) disable iff (!rst_n)
    state inside {SEND, HOLD} |=> clk_divider == CLK_DIVIDE'($past(clk_divider) + 1))
    else $error("clock divider did not increment");

  // Shift only on a divider wrap
  a_shift_wrap: assert property (@(posedge clk) disable iff (!rst_n)
    state == SEND && div_wrap |=> data_shift == {$past(data_shift[6:0]), 1'b0})
    else $error("data not shifted at divider wrap");

  a_shift_hold: assert property (@(posedge clk) disable iff (!rst_n)
    state == SEND && !div_wrap |=> data_shift == $past(data_shift))
    else $error("data shifted away from a divider wrap");

  // sdo walks the captured byte MSB first, one bit per shift
  a_sdo_msb: assert property (@(posedge clk) disable iff (!rst_n)
    state == SEND |-> pins.sdo == sent_byte[3'd7 - shift_counter])
    else $error("sdo is not the next MSB of the captured byte");

  // fin rises only when HOLD has run its full bit period
  a_fin_done: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(fin) |-> $past(state == HOLD && div_wrap))
    else $error("fin rose outside the end of HOLD");

  a_fin_latency: assert property (@(posedge clk) disable iff (!rst_n)
    state == IDLE && start |=> !fin [*FIN_LATENCY] ##1 fin)
    else $error("fin did not arrive exactly one byte plus hold after start");

endmodule

bind spi_master spi_master_props #(
  .CLK_DIVIDE (CLK_DIVIDE)
) props0 (
  .clk           (clk),
  .rst_n         (rst_n),
  .start         (start),
  .data          (data),
  .fin           (fin),
  .pins          (pins),
  .state         (state),
  .clk_divider   (clk_divider),
  .data_shift    (data_shift),
  .shift_counter (shift_counter)
);

// ==== tests/spi_tx_tb.sv ====
/*
  SPI transmitter testbench: random push bursts, FIFO and SPI slave model,
  byte, timing and counter checks
*/
`timescale 1ns/1ps
`include "spi_tx_defs.svh"

module spi_tx_tb;
  import spi_tx_pkg::*;

  localparam int P              = 1 << `SPI_CLK_DIVIDE;
  localparam int DEPTH          = `SPI_FIFO_DEPTH;
  localparam int PUSH_ATTEMPTS  = 200;
  localparam int TIMEOUT_CYCLES = PUSH_ATTEMPTS * (9 * 8 + 4) + 2000;
  localparam spi_pins_t PINS_IDLE = '{csn: 1'b1, sclk: 1'b0, sdo: 1'b0};

  logic       clk;
  logic       rst_n;
  logic       push;
  spi_byte_t  push_data;
  logic       full;
  logic       empty;
  spi_pins_t  pins;
  logic       byte_done;
  spi_count_t bytes_sent;

  logic [31:0] lcg_state = 32'hf7be080b;

  // FIFO and line model
  spi_byte_t model_q[$];
  int        occ = 0;
  int        accepted = 0;
  int        dropped = 0;
  int        windows = 0;
  int        done_pulses = 0;
  logic      pend_push = 1'b0;
  spi_byte_t pend_data = '0;
  spi_pins_t prev_pins = PINS_IDLE;
  spi_byte_t shift_in = '0;
  int        rise_cnt = 0;
  int        high_len = 0;
  int        since_rise = 0;
  int        cycle_cnt = 0;

  spi_tx_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (push),
    .push_data  (push_data),
    .full       (full),
    .empty      (empty),
    .pins       (pins),
    .byte_done  (byte_done),
    .bytes_sent (bytes_sent)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_byte(string name, spi_byte_t exp, spi_byte_t act);
    if (exp !== act) begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_pins(string name, spi_pins_t exp, spi_pins_t act);
    if (exp !== act) begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(string name, spi_count_t exp, spi_count_t act);
    if (exp !== act) begin
      $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_cycles(string name, int exp, int act);
    if (exp != act) begin
      $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  // Slave and FIFO model, sampled mid-cycle where outputs are settled
  always @(negedge clk) begin : line_monitor
    logic      pop_now;
    logic      push_ok;
    spi_byte_t exp_byte;

    if (rst_n) begin
      // A falling csn means the FIFO head was popped on the last edge
      pop_now = prev_pins.csn && !pins.csn;
      push_ok = pend_push && (occ < DEPTH);
      if (push_ok) begin
        model_q.push_back(pend_data);
        accepted++;
      end else if (pend_push) begin
        dropped++;
      end
      occ = occ + int'(push_ok) - int'(pop_now);
      check_flag("full", occ == DEPTH, full);
      check_flag("empty", occ == 0, empty);

      if (pop_now) begin
        shift_in   = '0;
        rise_cnt   = 0;
        since_rise = 0;
        high_len   = 0;
      end

      if (pins.csn) begin
        check_flag("pins.sclk", 1'b0, pins.sclk);
      end else begin
        since_rise++;
        if (!prev_pins.sclk && pins.sclk) begin
          if (rise_cnt > 0) begin
            check_cycles("sclk period", P, since_rise);
          end
          shift_in   = {shift_in[6:0], pins.sdo};
          rise_cnt++;
          since_rise = 0;
        end
        if (pins.sclk) begin
          high_len++;
        end
        if (prev_pins.sclk && !pins.sclk) begin
          check_cycles("sclk high phase", P / 2, high_len);
          high_len = 0;
        end
      end

      // End of a byte frame
      if (!prev_pins.csn && pins.csn) begin
        windows++;
        check_cycles("sclk rising edges", 8, rise_cnt);
        if (model_q.size() == 0) begin
          $display("Error: a byte went out on the line with nothing pushed");
          abort_run();
        end else begin
          exp_byte = model_q.pop_front();
          check_byte("received byte", exp_byte, shift_in);
          check_count("bytes_sent per frame", spi_count_t'(windows), bytes_sent);
        end
      end

      if (byte_done) begin
        done_pulses++;
      end
      check_count("bytes_sent per byte_done", spi_count_t'(done_pulses), bytes_sent);

      // Values driven now are sampled on the next rising edge
      pend_push = push;
      pend_data = push_data;
      prev_pins = pins;
    end
  end

  initial begin : watchdog
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    abort_run();
  end

  initial begin : stimulus
    int attempts;
    int burst_len;
    int gap_len;

    rst_n     = 1'b0;
    push      = 1'b0;
    push_data = '0;
    attempts  = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // Idle line before the first push
    repeat (2) @(negedge clk);
    check_pins("pins", PINS_IDLE, pins);
    check_flag("empty", 1'b1, empty);
    check_flag("full", 1'b0, full);
    check_count("bytes_sent", '0, bytes_sent);

    // Bursts overfill the FIFO, gaps let it drain
    while (attempts < PUSH_ATTEMPTS) begin
      burst_len = 4 + int'((lcg_next() >> 8) % 16);
      for (int i = 0; i < burst_len && attempts < PUSH_ATTEMPTS; i++) begin
        @(posedge clk);
        push      <= 1'b1;
        push_data <= spi_byte_t'(lcg_next() >> 16);
        attempts++;
      end
      @(posedge clk);
      push    <= 1'b0;
      gap_len = int'((lcg_next() >> 12) % 64);
      repeat (gap_len) @(posedge clk);
    end

    repeat (2) @(posedge clk);
    while (windows < accepted) begin
      @(posedge clk);
    end

    check_count("bytes_sent", spi_count_t'(accepted), bytes_sent);
    check_flag("empty", 1'b1, empty);
    if (model_q.size() == 0 && accepted + dropped == PUSH_ATTEMPTS) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Error: pushed bytes and bytes seen on the line do not add up");
      abort_run();
    end
  end

endmodule

// ==== spi_tx.f ====
+incdir+src
src/spi_tx_pkg.sv
src/spi_tx_fifo.sv
src/spi_master.sv
src/spi_tx_sequencer.sv
src/spi_tx_top.sv
tests/spi_master_props.sv
tests/spi_tx_tb.sv

// ==== Bender.yml ====
package:
  name: spi_tx

export_include_dirs:
  - src

sources:
  - files:
      - src/spi_tx_pkg.sv
      - src/spi_tx_fifo.sv
      - src/spi_master.sv
      - src/spi_tx_sequencer.sv
      - src/spi_tx_top.sv
  - target: test
    files:
      - tests/spi_master_props.sv
      - tests/spi_tx_tb.sv
